// File: verilog/ram_consts.svh
// RAM subsystem constants
`ifndef RAM_CONSTS_SVH
`define RAM_CONSTS_SVH

// Array geometry
`define RAM_ADDR_WID 8
`define RAM_DATA_WID 32
`define RAM_DEPTH 256

// Cycles from an accepted request to its ack
`define RAM_WR_LATENCY 1
`define RAM_RD_LATENCY 2

`endif

// File: verilog/ram_pkg.sv
// RAM subsystem types
`default_nettype none

`include "ram_consts.svh"

package ram_pkg;

    // Address and data words
    typedef logic [`RAM_ADDR_WID-1:0] addr_t;
    typedef logic [`RAM_DATA_WID-1:0] data_t;

    // Clear controller states
    typedef enum logic {
        INIT_CLEAR,
        INIT_READY
    } init_state_e;

endpackage : ram_pkg

`default_nettype wire

// File: verilog/ram_port_if.sv
// RAM port signal bundle
`timescale 1ns/1ps
`default_nettype none

interface ram_port_if
    import ram_pkg::*;
();

    // Request toward the memory
    logic  en;
    logic  wr;
    addr_t addr;
    data_t wr_data;

    // Response back to the requester
    data_t rd_data;

    modport requester (
        output en,
        output wr,
        output addr,
        output wr_data,
        input  rd_data
    );

    modport memory (
        input  en,
        input  wr,
        input  addr,
        input  wr_data,
        output rd_data
    );

endinterface : ram_port_if

`default_nettype wire

// File: verilog/ram_ack_pipe.sv
// Accept to ack delay line
`timescale 1ns/1ps
`default_nettype none

module ram_ack_pipe #(
    parameter int LATENCY = 1
) (
    input  logic clk_A,
    input  logic reset,
    input  logic go,
    output logic ack
);

    logic [LATENCY-1:0] stage;

    // Shift the strobe one stage per edge
    always_ff @(posedge clk_A) begin
        if (reset) begin
            stage <= '0;
        end else begin
            stage[0] <= go;
            for (int i = 1; i < LATENCY; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign ack = stage[LATENCY-1];

endmodule : ram_ack_pipe

`default_nettype wire

// File: verilog/ram_init_ctrl.sv
// RAM clear and request gating
`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module ram_init_ctrl
    import ram_pkg::*;
(
    input  logic clk_A,
    input  logic reset,

    ram_port_if.memory    ext_a,
    ram_port_if.memory    ext_b,
    ram_port_if.requester core_a,
    ram_port_if.requester core_b,

    output logic wr_go_a,
    output logic rd_go_a,
    output logic wr_go_b,
    output logic rd_go_b,
    output logic init_done
);

    init_state_e state;
    addr_t       clr_addr;
    logic        ready;

    // ------------------------------------------------------------------
    // Clear sequence
    // ------------------------------------------------------------------
    // One word per cycle from address 0 up to the last word
    always_ff @(posedge clk_A) begin
        if (reset) begin
            state    <= INIT_CLEAR;
            clr_addr <= '0;
        end else if (state == INIT_CLEAR) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == addr_t'(`RAM_DEPTH - 1)) begin
                state <= INIT_READY;
            end
        end
    end

    assign ready     = (state == INIT_READY);
    assign init_done = ready;

    // ------------------------------------------------------------------
    // Core port muxing
    // ------------------------------------------------------------------
    always_comb begin
        if (ready) begin
            core_a.en      = ext_a.en;
            core_a.wr      = ext_a.wr;
            core_a.addr    = ext_a.addr;
            core_a.wr_data = ext_a.wr_data;
            core_b.en      = ext_b.en;
            core_b.wr      = ext_b.wr;
            core_b.addr    = ext_b.addr;
            core_b.wr_data = ext_b.wr_data;
        end else begin
            // Port A idle while port B writes zero at the sweep address
            core_a.en      = 1'b0;
            core_a.wr      = 1'b0;
            core_a.addr    = '0;
            core_a.wr_data = '0;
            core_b.en      = 1'b1;
            core_b.wr      = 1'b1;
            core_b.addr    = clr_addr;
            core_b.wr_data = '0;
        end
    end

    // Read data passes back untouched
    assign ext_a.rd_data = core_a.rd_data;
    assign ext_b.rd_data = core_b.rd_data;

    // ------------------------------------------------------------------
    // Accept strobes
    // ------------------------------------------------------------------
    // Only requests taken once the clear is over count
    assign wr_go_a = ready && ext_a.en && ext_a.wr;
    assign rd_go_a = ready && ext_a.en && !ext_a.wr;
    assign wr_go_b = ready && ext_b.en && ext_b.wr;
    assign rd_go_b = ready && ext_b.en && !ext_b.wr;

endmodule : ram_init_ctrl

`default_nettype wire

// File: verilog/ram_core.sv
// Dual-port storage array
`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module ram_core
    import ram_pkg::*;
(
    input  logic clk_A,

    ram_port_if.memory port_a,
    ram_port_if.memory port_b
);

    data_t mem [`RAM_DEPTH];

    // Read pipeline first stage and output stage
    data_t rd_q_a;
    data_t rd_q_b;
    data_t rd_out_a;
    data_t rd_out_b;

    // ------------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------------
    // Port A is written last so it wins a same-address collision
    always_ff @(posedge clk_A) begin
        if (port_b.en && port_b.wr) begin
            mem[port_b.addr] <= port_b.wr_data;
        end
        if (port_a.en && port_a.wr) begin
            mem[port_a.addr] <= port_a.wr_data;
        end
    end

    // ------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------
    // Read-first since the array value sampled here is the one before
    // any write landing on the same edge
    always_ff @(posedge clk_A) begin
        if (port_a.en && !port_a.wr) begin
            rd_q_a <= mem[port_a.addr];
        end
        if (port_b.en && !port_b.wr) begin
            rd_q_b <= mem[port_b.addr];
        end
    end

    // Output register one edge behind the array read
    always_ff @(posedge clk_A) begin
        rd_out_a <= rd_q_a;
        rd_out_b <= rd_q_b;
    end

    assign port_a.rd_data = rd_out_a;
    assign port_b.rd_data = rd_out_b;

endmodule : ram_core

`default_nettype wire

// File: verilog/ram_tdp.sv
// True dual-port RAM top level
`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module ram_tdp
    import ram_pkg::*;
(
    input  logic  clk_A,
    input  logic  reset,

    // Port A
    input  logic  en_a,
    input  logic  wr_a,
    input  addr_t addr_a,
    input  data_t wr_data_a,
    output logic  wr_ack_a,
    output logic  rd_ack_a,
    output data_t rd_data_a,

    // Port B
    input  logic  en_b,
    input  logic  wr_b,
    input  addr_t addr_b,
    input  data_t wr_data_b,
    output logic  wr_ack_b,
    output logic  rd_ack_b,
    output data_t rd_data_b,

    output logic  init_done
);

    logic wr_go_a;
    logic rd_go_a;
    logic wr_go_b;
    logic rd_go_b;

    ram_port_if ext_a ();
    ram_port_if ext_b ();
    ram_port_if core_a ();
    ram_port_if core_b ();

    // ------------------------------------------------------------------
    // External ports into bundles
    // ------------------------------------------------------------------
    assign ext_a.en      = en_a;
    assign ext_a.wr      = wr_a;
    assign ext_a.addr    = addr_a;
    assign ext_a.wr_data = wr_data_a;
    assign rd_data_a     = ext_a.rd_data;

    assign ext_b.en      = en_b;
    assign ext_b.wr      = wr_b;
    assign ext_b.addr    = addr_b;
    assign ext_b.wr_data = wr_data_b;
    assign rd_data_b     = ext_b.rd_data;

    // ------------------------------------------------------------------
    // Controller and storage
    // ------------------------------------------------------------------
    ram_init_ctrl i_ram_init_ctrl (
        .clk_A     ( clk_A ),
        .reset     ( reset ),
        .ext_a     ( ext_a ),
        .ext_b     ( ext_b ),
        .core_a    ( core_a ),
        .core_b    ( core_b ),
        .wr_go_a   ( wr_go_a ),
        .rd_go_a   ( rd_go_a ),
        .wr_go_b   ( wr_go_b ),
        .rd_go_b   ( rd_go_b ),
        .init_done ( init_done )
    );

    ram_core i_ram_core (
        .clk_A  ( clk_A ),
        .port_a ( core_a ),
        .port_b ( core_b )
    );

    // ------------------------------------------------------------------
    // Ack pipelines
    // ------------------------------------------------------------------
    ram_ack_pipe #(.LATENCY(`RAM_WR_LATENCY)) i_wr_ack_pipe_a (
        .clk_A ( clk_A ),
        .reset ( reset ),
        .go    ( wr_go_a ),
        .ack   ( wr_ack_a )
    );

    ram_ack_pipe #(.LATENCY(`RAM_RD_LATENCY)) i_rd_ack_pipe_a (
        .clk_A ( clk_A ),
        .reset ( reset ),
        .go    ( rd_go_a ),
        .ack   ( rd_ack_a )
    );

    ram_ack_pipe #(.LATENCY(`RAM_WR_LATENCY)) i_wr_ack_pipe_b (
        .clk_A ( clk_A ),
        .reset ( reset ),
        .go    ( wr_go_b ),
        .ack   ( wr_ack_b )
    );

    ram_ack_pipe #(.LATENCY(`RAM_RD_LATENCY)) i_rd_ack_pipe_b (
        .clk_A ( clk_A ),
        .reset ( reset ),
        .go    ( rd_go_b ),
        .ack   ( rd_ack_b )
    );

endmodule : ram_tdp

`default_nettype wire

// File: testbench/ram_tdp_chk.sv
// Ack timing and reset checks
`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module ram_tdp_chk (
    input logic clk_A,
    input logic reset,
    input logic init_done,
    input logic wr_go_a, rd_go_a, wr_go_b, rd_go_b,
    input logic wr_ack_a, rd_ack_a, wr_ack_b, rd_ack_b
);

    int unsigned fail_count = 0;

    task automatic note_failure(input string what);
        $error("%s", what);
        fail_count++;
    endtask

    // Each ack is its accept strobe delayed by the fixed latency
    a_wr_ack_a : assert property (@(posedge clk_A) disable iff (reset)
        wr_ack_a == $past(wr_go_a, `RAM_WR_LATENCY)) else note_failure("wr_ack_a timing");
    a_rd_ack_a : assert property (@(posedge clk_A) disable iff (reset)
        rd_ack_a == $past(rd_go_a, `RAM_RD_LATENCY)) else note_failure("rd_ack_a timing");
    a_wr_ack_b : assert property (@(posedge clk_A) disable iff (reset)
        wr_ack_b == $past(wr_go_b, `RAM_WR_LATENCY)) else note_failure("wr_ack_b timing");
    a_rd_ack_b : assert property (@(posedge clk_A) disable iff (reset)
        rd_ack_b == $past(rd_go_b, `RAM_RD_LATENCY)) else note_failure("rd_ack_b timing");

    // init_done stays up once the clear is over
    a_done_hold : assert property (@(posedge clk_A) disable iff (reset)
        $past(init_done) |-> init_done) else note_failure("init_done fell");

    // Nothing is acknowledged before the clear completes
    a_no_early_ack : assert property (@(posedge clk_A) disable iff (reset)
        !init_done |-> !(wr_ack_a || rd_ack_a || wr_ack_b || rd_ack_b))
        else note_failure("ack while init_done is low");

    a_reset_clear : assert property (@(posedge clk_A)
        reset |=> !(init_done || wr_ack_a || rd_ack_a || wr_ack_b || rd_ack_b))
        else note_failure("ack or init_done high after reset");

endmodule : ram_tdp_chk

`default_nettype wire

// File: testbench/ram_tdp_tb.sv
// Dual-port RAM testbench
`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module ram_tdp_tb
    import ram_pkg::*;
();

    logic  clk_A;
    logic  reset;
    logic  init_done;
    logic  en [2];
    logic  wr [2];
    addr_t addr [2];
    data_t wr_data [2];
    logic  wack [2];
    logic  rack [2];
    data_t rdat [2];

    // Reference memory and the responses still due on each port
    data_t model [addr_t];
    logic  exp_wack [2];
    logic  exp_rack [2][2];
    data_t exp_rdat [2][2];
    int    cycle_no;
    int    seed;
    addr_t test_addr;
    data_t test_data;

    ram_tdp ram_tdp_i (
        .clk_A(clk_A), .reset(reset), .init_done(init_done),
        .en_a(en[0]), .wr_a(wr[0]), .addr_a(addr[0]), .wr_data_a(wr_data[0]),
        .wr_ack_a(wack[0]), .rd_ack_a(rack[0]), .rd_data_a(rdat[0]),
        .en_b(en[1]), .wr_b(wr[1]), .addr_b(addr[1]), .wr_data_b(wr_data[1]),
        .wr_ack_b(wack[1]), .rd_ack_b(rack[1]), .rd_data_b(rdat[1])
    );

    bind ram_tdp ram_tdp_chk i_ram_tdp_chk (
        .clk_A(clk_A), .reset(reset), .init_done(init_done),
        .wr_go_a(wr_go_a), .rd_go_a(rd_go_a), .wr_go_b(wr_go_b), .rd_go_b(rd_go_b),
        .wr_ack_a(wr_ack_a), .rd_ack_a(rd_ack_a), .wr_ack_b(wr_ack_b), .rd_ack_b(rd_ack_b)
    );

    always #10 clk_A = ~clk_A;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic compare_data(input string what, input data_t got, input data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0d ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0d ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    function automatic data_t model_read(input addr_t a);
        return model.exists(a) ? model[a] : '0;
    endfunction

    // ------------------------------------------------------------------
    // Per-cycle driver and response check
    // ------------------------------------------------------------------
    // Requests count only once the 256-word clear has run
    task automatic clock_step(input logic ea, input logic wa, input addr_t aa, input data_t da,
                              input logic eb, input logic wb, input addr_t ab, input data_t db);
        logic take;
        @(negedge clk_A);
        cycle_no++;
        take = (cycle_no >= `RAM_DEPTH);
        if (ram_tdp_i.i_ram_tdp_chk.fail_count != 0) begin
            abort_run("An assertion in the checker module failed");
        end
        compare_bit("init_done", init_done, take);
        en      = '{ea, eb};
        wr      = '{wa, wb};
        addr    = '{aa, ab};
        wr_data = '{da, db};
        for (int p = 0; p < 2; p++) begin
            compare_bit($sformatf("wr_ack_%s", p ? "b" : "a"), wack[p], exp_wack[p]);
            compare_bit($sformatf("rd_ack_%s", p ? "b" : "a"), rack[p], exp_rack[p][0]);
            if (exp_rack[p][0]) begin
                compare_data($sformatf("rd_data_%s", p ? "b" : "a"), rdat[p], exp_rdat[p][0]);
            end
            exp_wack[p]    = take && en[p] && wr[p];
            exp_rack[p][0] = exp_rack[p][1];
            exp_rdat[p][0] = exp_rdat[p][1];
            exp_rack[p][1] = take && en[p] && !wr[p];
            exp_rdat[p][1] = model_read(addr[p]);
        end
        // Reads above saw the old data; port A goes last so it wins
        for (int p = 1; p >= 0; p--) begin
            if (take && en[p] && wr[p]) begin
                model[addr[p]] = wr_data[p];
            end
        end
    endtask

    task automatic idle_step();
        clock_step(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
    endtask

    // Few addresses so hits and collisions are common
    task automatic random_step();
        logic [5:0] r;
        r = 6'($random(seed));
        clock_step(r[0] | r[1], r[2], addr_t'($random(seed) & 15), data_t'($random(seed)),
                   r[3] | r[4], r[5], addr_t'($random(seed) & 15), data_t'($random(seed)));
    endtask

    task automatic wait_ack(input logic is_wr, input int p);
        int n;
        n = 0;
        do begin
            idle_step();
            n++;
            if (n > 8) begin
                abort_run($sformatf("Timeout waiting for an ack on port %0d", p));
            end
        end while (!(is_wr ? wack[p] : rack[p]));
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic test_clear();
        int n;
        n = 0;
        while (init_done !== 1'b1) begin
            random_step();
            n++;
            if (n > 2 * `RAM_DEPTH) begin
                abort_run("Timeout waiting for init_done after reset");
            end
        end
        repeat (16) begin
            clock_step(1'b1, 1'b0, addr_t'($random(seed)), '0,
                       1'b1, 1'b0, addr_t'($random(seed)), '0);
        end
    endtask

    task automatic test_write_read();
        test_addr = addr_t'($random(seed));
        test_data = data_t'($random(seed));
        clock_step(1'b1, 1'b1, test_addr, test_data, 1'b0, 1'b0, '0, '0);
        wait_ack(1'b1, 0);
        clock_step(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, test_addr, '0);
        wait_ack(1'b0, 1);
        compare_data("rd_data_b", rdat[1], test_data);
    endtask

    task automatic test_pipelined();
        repeat (400) begin
            random_step();
        end
    endtask

    task automatic test_collision();
        test_addr = addr_t'($random(seed));
        test_data = data_t'($random(seed));
        clock_step(1'b1, 1'b1, test_addr, test_data, 1'b1, 1'b1, test_addr, ~test_data);
        wait_ack(1'b1, 1);
        clock_step(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, test_addr, '0);
        wait_ack(1'b0, 1);
        compare_data("rd_data_b", rdat[1], test_data);
    endtask

    task automatic test_read_during_write();
        test_addr = addr_t'($random(seed));
        test_data = data_t'($random(seed));
        clock_step(1'b1, 1'b1, test_addr, test_data, 1'b0, 1'b0, '0, '0);
        wait_ack(1'b1, 0);
        clock_step(1'b1, 1'b0, test_addr, '0, 1'b1, 1'b1, test_addr, ~test_data);
        wait_ack(1'b0, 0);
        compare_data("rd_data_a", rdat[0], test_data);
        clock_step(1'b1, 1'b0, test_addr, '0, 1'b0, 1'b0, '0, '0);
        wait_ack(1'b0, 0);
        compare_data("rd_data_a", rdat[0], ~test_data);
    endtask

    initial begin
        clk_A    = 1'b0;
        reset    = 1'b1;
        seed     = 32'h5a59_878c;
        cycle_no = 0;
        en       = '{default: 1'b0};
        wr       = '{default: 1'b0};
        addr     = '{default: '0};
        wr_data  = '{default: '0};
        exp_wack = '{default: 1'b0};
        exp_rack = '{default: 1'b0};
        exp_rdat = '{default: '0};
        repeat (8) @(negedge clk_A);
        reset = 1'b0;
        test_clear();
        test_write_read();
        test_pipelined();
        test_collision();
        test_read_during_write();
        repeat (4) begin
            idle_step();
        end
        if (ram_tdp_i.i_ram_tdp_chk.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : ram_tdp_tb

`default_nettype wire

// File: ram_tdp.f
+incdir+verilog
verilog/ram_pkg.sv
verilog/ram_port_if.sv
verilog/ram_ack_pipe.sv
verilog/ram_init_ctrl.sv
verilog/ram_core.sv
verilog/ram_tdp.sv
testbench/ram_tdp_chk.sv
testbench/ram_tdp_tb.sv

// File: Bender.yml
package:
  name: ram_tdp

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ram_pkg.sv
      - verilog/ram_port_if.sv
      - verilog/ram_ack_pipe.sv
      - verilog/ram_init_ctrl.sv
      - verilog/ram_core.sv
      - verilog/ram_tdp.sv
      - testbench/ram_tdp_chk.sv
      - testbench/ram_tdp_tb.sv
